//--- Makefile
# Verilator build and run of the array unit testbench

OBJ = obj_dir
LOG = sim.log

.PHONY: all lint clean

all: $(OBJ)/arrayUnitTb
	./$(OBJ)/arrayUnitTb | tee $(LOG)
	grep -qx "SIMULATION PASSED" $(LOG)

$(OBJ)/arrayUnitTb: files.f logic/*.sv logic/*.svh test/*.sv
	verilator --binary -Wno-fatal -f files.f --top-module arrayUnitTb \
		-Mdir $(OBJ) -o arrayUnitTb

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module arrayUnitTb

clean:
	rm -rf $(OBJ) $(LOG)

//--- files.f
+incdir+logic
logic/arrayDataPkg.sv
logic/arrayOpsPkg.sv
logic/arrayAllocator.sv
logic/elementStore.sv
logic/arrayCommit.sv
logic/arrayUnit.sv
test/arrayUnitTb.sv

//--- logic/arrayAllocator.sv
/*
  Array allocator
  Keeps allocation flags, the freed-handle stack and array sizes, checks
  each command and registers a verdict for the commit stage
*/
`timescale 1ns/1ps
`default_nettype none

`include "arrayUnit_defines.svh"

module arrayAllocator (
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       commandStrobe,
  input  wire arrayOpsPkg::arrayOp_t opcode,
  input  wire arrayDataPkg::handle_t arrayHandle,
  input  wire arrayDataPkg::index_t  elementIndex,
  output logic                      verdictValid,
  output arrayOpsPkg::arrayOp_t     verdictOp,
  output arrayDataPkg::handle_t     verdictHandle,
  output arrayDataPkg::index_t      verdictSlot,
  output arrayDataPkg::size_t       verdictSize,
  output arrayOpsPkg::arrayError_t  verdictError
);
  import arrayDataPkg::*;
  import arrayOpsPkg::*;

  typedef logic [$bits(handle_t):0] count_t;    // 0 up to ARRAY_COUNT

  logic [`ARRAY_COUNT-1:0] allocFlags;
  size_t                   sizes [`ARRAY_COUNT];
  handle_t                 freeStack [`ARRAY_COUNT];
  count_t                  freeTop;               // Entries on the free stack
  count_t                  highWater;             // Handles ever handed out

  size_t       curSize;
  size_t       nextSize;
  handle_t     allocHandle;
  index_t      slot;
  arrayError_t checkError;

  // ----------------------------------------
  // Command check
  // ----------------------------------------
  always_comb begin
    curSize     = sizes[arrayHandle];
    nextSize    = curSize;
    allocHandle = '0;
    slot        = elementIndex;
    checkError  = errNone;

    if (opcode == Alloc) begin
      if (freeTop != '0)
        allocHandle = freeStack[handle_t'(freeTop - 1'b1)];   // Last freed first
      else if (highWater < `ARRAY_COUNT)
        allocHandle = handle_t'(highWater);
      else
        checkError = errOutOfMemory;
      nextSize = size_t'(allocHandle);                        // Handle reported as size
    end else if (count_t'(arrayHandle) >= highWater) begin
      checkError = errNotAllocated;
    end else if (!allocFlags[arrayHandle]) begin
      checkError = errFreed;
    end else if ((opcode == Read || isAluOp(opcode)) && size_t'(elementIndex) >= curSize) begin
      checkError = errOutOfBounds;
    end else if (opcode == Push && curSize == `ARRAY_LENGTH) begin
      checkError = errFull;
    end else if (opcode == Pop && curSize == '0) begin
      checkError = errEmpty;
    end

    case (opcode)
      Write: if (size_t'(elementIndex) >= curSize) nextSize = size_t'(elementIndex) + 1'b1;
      Push: begin
        slot     = index_t'(curSize);                         // Next free slot
        nextSize = curSize + 1'b1;
      end
      Pop: begin
        slot     = index_t'(curSize - 1'b1);                  // Top element
        nextSize = curSize - 1'b1;
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // Bookkeeping
  // ----------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocFlags   <= '0;
      freeTop      <= '0;
      highWater    <= '0;
      verdictValid <= 1'b0;
      for (int i = 0; i < `ARRAY_COUNT; i++) begin
        sizes[i]     <= '0;
        freeStack[i] <= '0;
      end
    end else begin
      verdictValid <= commandStrobe;
      if (commandStrobe && checkError == errNone) begin
        case (opcode)
          Alloc: begin
            allocFlags[allocHandle] <= 1'b1;
            sizes[allocHandle]      <= '0;                    // Starts empty
            if (freeTop != '0) freeTop <= freeTop - 1'b1;
            else               highWater <= highWater + 1'b1;
          end
          Free: begin
            allocFlags[arrayHandle]          <= 1'b0;
            freeStack[handle_t'(freeTop)]    <= arrayHandle;
            freeTop                          <= freeTop + 1'b1;
          end
          default: sizes[arrayHandle] <= nextSize;
        endcase
      end
    end
  end

  // Verdict payload for stage 2
  always_ff @(posedge clock) begin
    if (commandStrobe) begin
      verdictOp     <= opcode;
      verdictHandle <= arrayHandle;
      verdictSlot   <= slot;
      verdictSize   <= nextSize;
      verdictError  <= checkError;
    end
  end

endmodule

`default_nettype wire

//--- logic/arrayCommit.sv
/*
  Commit stage
  Applies the element operation to the fetched row, writes the new value
  back and registers the result of each command
*/
`timescale 1ns/1ps
`default_nettype none

module arrayCommit (
  input  wire                          clock,
  input  wire                          reset,
  input  wire                          commandStrobe,
  input  wire arrayDataPkg::element_t   dataIn,
  input  wire                          verdictValid,
  input  wire arrayOpsPkg::arrayOp_t    verdictOp,
  input  wire arrayDataPkg::handle_t    verdictHandle,
  input  wire arrayDataPkg::index_t     verdictSlot,
  input  wire arrayDataPkg::size_t      verdictSize,
  input  wire arrayOpsPkg::arrayError_t verdictError,
  input  wire arrayDataPkg::row_t       rowData,
  output logic                         writeStrobe,
  output arrayDataPkg::handle_t        writeHandle,
  output arrayDataPkg::index_t         writeIndex,
  output arrayDataPkg::element_t       writeData,
  output logic                         resultStrobe,
  output arrayDataPkg::element_t       dataOut,
  output arrayOpsPkg::arrayError_t     errorCode
);
  import arrayDataPkg::*;
  import arrayOpsPkg::*;

  element_t storedData;                         // Operand of the command
  element_t oldElement;
  element_t newElement;
  element_t resultData;

  always_ff @(posedge clock) begin
    if (commandStrobe) storedData <= dataIn;
  end

  // ----------------------------------------
  // Element operation
  // ----------------------------------------
  always_comb begin
    oldElement = rowData[verdictSlot];
    case (verdictOp)
      Write, Push: newElement = storedData;
      Add:         newElement = oldElement + storedData;   // Wraps at 12 bits
      Subtract:    newElement = oldElement - storedData;
      And:         newElement = oldElement & storedData;
      Or:          newElement = oldElement | storedData;
      Xor:         newElement = oldElement ^ storedData;
      default:     newElement = oldElement;
    endcase
  end

  assign writeStrobe = verdictValid && verdictError == errNone && changesElement(verdictOp);
  assign writeHandle = verdictHandle;
  assign writeIndex  = verdictSlot;
  assign writeData   = newElement;

  // ----------------------------------------
  // Result
  // ----------------------------------------
  always_comb begin
    if (verdictError != errNone) begin
      resultData = '0;
    end else begin
      case (verdictOp)
        Write, Push: resultData = storedData;
        Read, Pop:   resultData = oldElement;
        Size, Alloc: resultData = element_t'(verdictSize);   // Zero extended
        Free:        resultData = '0;
        default:     resultData = newElement;              // Arithmetic and logic
      endcase
    end
  end

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) resultStrobe <= 1'b0;
    else        resultStrobe <= verdictValid;
  end

  always_ff @(posedge clock) begin
    if (verdictValid) begin
      dataOut   <= resultData;
      errorCode <= verdictError;
    end
  end

endmodule

`default_nettype wire

//--- logic/arrayDataPkg.sv
/*
  Array data types
  Handles, indices, sizes, elements and whole rows of the array unit
*/
`default_nettype none

package arrayDataPkg;

`include "arrayUnit_defines.svh"

  // ----------------------------------------
  // Addressing
  // ----------------------------------------
  typedef logic [$clog2(`ARRAY_COUNT)-1:0] handle_t;  // Array number
  typedef logic [`INDEX_BITS-1:0]          index_t;   // Element position
  typedef logic [`INDEX_BITS:0]            size_t;    // 0 up to ARRAY_LENGTH

  // ----------------------------------------
  // Payload
  // ----------------------------------------
  typedef logic [`DATA_BITS-1:0]           element_t; // Stored value
  typedef element_t [`ARRAY_LENGTH-1:0]    row_t;     // One full array

endpackage

`default_nettype wire

//--- logic/arrayOpsPkg.sv
/*
  Array operations
  Opcode and error code enumerations, with opcode classification helpers
*/
`default_nettype none

package arrayOpsPkg;

  typedef enum logic [3:0] {
    Alloc,                                  // New array, returns handle
    Free,                                   // Release array for reuse
    Write,                                  // Store, may extend size
    Read,                                   // Fetch element
    Size,                                   // Current element count
    Push,                                   // Append at the end
    Pop,                                    // Remove from the end
    Add,                                    // Element plus data
    Subtract,                               // Element minus data
    And,
    Or,
    Xor
  } arrayOp_t;

  typedef enum logic [2:0] {
    errNone,
    errNotAllocated,                        // Beyond the high-water mark
    errFreed,                               // Allocated once, now free
    errOutOfBounds,                         // Index at or above size
    errFull,
    errEmpty,
    errOutOfMemory                          // No handle left for Alloc
  } arrayError_t;

  // Read-modify-write on a stored element
  function automatic logic isAluOp(arrayOp_t op);
    return op inside {Add, Subtract, And, Or, Xor};
  endfunction

  function automatic logic changesElement(arrayOp_t op);
    return isAluOp(op) || op == Write || op == Push;
  endfunction

endpackage

`default_nettype wire

//--- logic/arrayUnit.sv
/*
  Array memory unit
  Allocator and element store in stage 1, commit in stage 2; each
  command returns its result two cycles after the strobe
*/
`timescale 1ns/1ps
`default_nettype none

module arrayUnit (
  input  wire                        clock,
  input  wire                        reset,
  input  wire                        commandStrobe,
  input  wire arrayOpsPkg::arrayOp_t  opcode,
  input  wire arrayDataPkg::handle_t  arrayHandle,
  input  wire arrayDataPkg::index_t   elementIndex,
  input  wire arrayDataPkg::element_t dataIn,
  output logic                       resultStrobe,
  output arrayDataPkg::element_t     dataOut,
  output arrayOpsPkg::arrayError_t   errorCode
);
  import arrayDataPkg::*;
  import arrayOpsPkg::*;

  // Stage 1 to stage 2
  logic        verdictValid;
  arrayOp_t    verdictOp;
  handle_t     verdictHandle;
  index_t      verdictSlot;
  size_t       verdictSize;
  arrayError_t verdictError;
  row_t        rowData;

  // Write-back path
  logic     writeStrobe;
  handle_t  writeHandle;
  index_t   writeIndex;
  element_t writeData;

  arrayAllocator allocator (
    .clock, .reset, .commandStrobe, .opcode, .arrayHandle, .elementIndex,
    .verdictValid, .verdictOp, .verdictHandle, .verdictSlot, .verdictSize,
    .verdictError
  );

  elementStore store (
    .clock, .commandStrobe, .arrayHandle,
    .writeStrobe, .writeHandle, .writeIndex, .writeData,
    .rowData
  );

  arrayCommit commit (
    .clock, .reset, .commandStrobe, .dataIn,
    .verdictValid, .verdictOp, .verdictHandle, .verdictSlot, .verdictSize,
    .verdictError, .rowData,
    .writeStrobe, .writeHandle, .writeIndex, .writeData,
    .resultStrobe, .dataOut, .errorCode
  );

endmodule

`default_nettype wire

//--- logic/arrayUnit_defines.svh
/*
  Array unit sizing
  Number of arrays, element index width and element width shared by
  the packages and the storage blocks
*/
`ifndef ARRAY_UNIT_DEFINES_SVH
`define ARRAY_UNIT_DEFINES_SVH

// ----------------------------------------
// Array geometry
// ----------------------------------------
`define ARRAY_COUNT  4                      // Arrays held by the unit
`define INDEX_BITS   2                      // Bits in an element index

`define ARRAY_LENGTH (1 << `INDEX_BITS)     // Elements per array

// ----------------------------------------
// Payload
// ----------------------------------------
`define DATA_BITS    12                     // Bits in one element

`endif

//--- logic/elementStore.sv
/*
  Element store
  Holds every element of every array, writes one element per write
  strobe and registers the row of the requested array with write-through
*/
`timescale 1ns/1ps
`default_nettype none

`include "arrayUnit_defines.svh"

module elementStore (
  input  wire                        clock,
  input  wire                        commandStrobe,
  input  wire arrayDataPkg::handle_t  arrayHandle,
  input  wire                        writeStrobe,
  input  wire arrayDataPkg::handle_t  writeHandle,
  input  wire arrayDataPkg::index_t   writeIndex,
  input  wire arrayDataPkg::element_t writeData,
  output arrayDataPkg::row_t         rowData
);
  import arrayDataPkg::*;

  element_t memory [`ARRAY_COUNT][`ARRAY_LENGTH];
  row_t     nextRow;

  // Row of the requested array, with a same-edge write merged in
  always_comb begin
    for (int i = 0; i < `ARRAY_LENGTH; i++) begin
      if (writeStrobe && writeHandle == arrayHandle && writeIndex == index_t'(i))
        nextRow[i] = writeData;                   // Write-through
      else
        nextRow[i] = memory[arrayHandle][i];
    end
  end

  always_ff @(posedge clock) begin
    if (writeStrobe)
      memory[writeHandle][writeIndex] <= writeData;
    if (commandStrobe)
      rowData <= nextRow;
  end

endmodule

`default_nettype wire

//--- test/arrayUnitTb.sv
/*
  Array unit testbench
  Applies a table of commands one per cycle and checks every result
  against the expected value and error code of its row
*/
`timescale 1ns/1ps
`default_nettype none

module arrayUnitTb;
  import arrayDataPkg::*;
  import arrayOpsPkg::*;

  typedef struct {
    string       name;
    arrayOp_t    op;
    handle_t     handle;
    index_t      index;
    element_t    data;
    element_t    expData;
    arrayError_t expError;
    int unsigned issued;                        // Edge count at drive time
  } testRow_t;

  logic        clock;
  logic        reset;
  logic        commandStrobe;
  arrayOp_t    opcode;
  handle_t     arrayHandle;
  index_t      elementIndex;
  element_t    dataIn;
  logic        resultStrobe;
  element_t    dataOut;
  arrayError_t errorCode;

  testRow_t    rows[$];
  testRow_t    pending[$];                      // Commands awaiting a result
  testRow_t    entry;
  testRow_t    outcome;
  int unsigned cycle;
  int unsigned timeoutCycles;
  int          valueErrors;
  int          protocolErrors;

  arrayUnit i_dut (
    .clock, .reset, .commandStrobe, .opcode, .arrayHandle, .elementIndex,
    .dataIn, .resultStrobe, .dataOut, .errorCode
  );

  always #5 clock = ~clock;                     // 10 ns period

  always @(posedge clock) cycle <= cycle + 1;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic checkElement(input string name, input element_t expected,
                              input element_t actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("Fail %s: dataOut expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic checkError(input string name, input arrayError_t expected,
                            input arrayError_t actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("Fail %s: errorCode expected %s, got %s", name, expected.name(), actual.name());
    end
  endtask

  // Results are stable around the falling edge
  always @(negedge clock) begin
    if (resultStrobe === 1'b1) begin
      if (pending.size() == 0) begin
        protocolErrors++;
        $display("A result strobe arrived with no command outstanding");
      end else begin
        outcome = pending.pop_front();
        if (cycle - outcome.issued != 2) begin
          protocolErrors++;
          $display("Result of %s arrived %0d cycles after its command instead of 2",
                   outcome.name, cycle - outcome.issued);
        end
        checkElement(outcome.name, outcome.expData, dataOut);
        checkError(outcome.name, outcome.expError, errorCode);
      end
    end
  end

  // ----------------------------------------
  // Command table
  // ----------------------------------------
  task automatic addRow(input string name, input arrayOp_t op, input int handle,
                        input int index, input int data, input int expData,
                        input arrayError_t expError);
    testRow_t row;
    row.name     = name;
    row.op       = op;
    row.handle   = handle_t'(handle);
    row.index    = index_t'(index);
    row.data     = element_t'(data);
    row.expData  = element_t'(expData);
    row.expError = expError;
    row.issued   = 0;
    rows.push_back(row);
  endtask

  task automatic buildTable();
    addRow("readNeverAlloc", Read,     0, 0, 'h000, 'h000, errNotAllocated);
    addRow("alloc0",         Alloc,    0, 0, 'h000, 'h000, errNone);
    addRow("alloc1",         Alloc,    0, 0, 'h000, 'h001, errNone);
    addRow("alloc2",         Alloc,    0, 0, 'h000, 'h002, errNone);
    addRow("alloc3",         Alloc,    0, 0, 'h000, 'h003, errNone);
    addRow("allocNoMemory",  Alloc,    0, 0, 'h000, 'h000, errOutOfMemory);
    // Add on the still empty array is rejected and leaves slot 0 alone
    addRow("addPastSize",    Add,      3, 0, 'h005, 'h000, errOutOfBounds);
    // Write past the end grows the array
    addRow("writeExtend",    Write,    3, 2, 'h5A5, 'h5A5, errNone);
    addRow("sizeAfterWrite", Size,     3, 0, 'h000, 'h003, errNone);
    addRow("readWritten",    Read,     3, 2, 'h000, 'h5A5, errNone);
    addRow("readUnwritten",  Read,     3, 0, 'h000, 'h000, errNone);
    addRow("readPastSize",   Read,     3, 3, 'h000, 'h000, errOutOfBounds);
    addRow("writeLow",       Write,    3, 0, 'h123, 'h123, errNone);
    addRow("readLow",        Read,     3, 0, 'h000, 'h123, errNone);
    addRow("sizeUnchanged",  Size,     3, 0, 'h000, 'h003, errNone);
    // Free and reuse, last freed first
    addRow("writeBeforeFree", Write,   2, 1, 'h777, 'h777, errNone);
    addRow("free2",          Free,     2, 0, 'h000, 'h000, errNone);
    addRow("free1",          Free,     1, 0, 'h000, 'h000, errNone);
    addRow("readFreed",      Read,     2, 1, 'h000, 'h000, errFreed);
    addRow("freeTwice",      Free,     2, 0, 'h000, 'h000, errFreed);
    addRow("reallocLast",    Alloc,    0, 0, 'h000, 'h001, errNone);
    addRow("reallocNext",    Alloc,    0, 0, 'h000, 'h002, errNone);
    addRow("allocNoMemory2", Alloc,    0, 0, 'h000, 'h000, errOutOfMemory);
    addRow("sizeRealloc",    Size,     2, 0, 'h000, 'h000, errNone);
    addRow("readKept",       Read,     3, 2, 'h000, 'h5A5, errNone);
    // Stack use of array 1
    addRow("popEmptyFirst",  Pop,      1, 0, 'h000, 'h000, errEmpty);
    addRow("push0",          Push,     1, 0, 'h111, 'h111, errNone);
    addRow("push1",          Push,     1, 0, 'h222, 'h222, errNone);
    addRow("push2",          Push,     1, 0, 'h333, 'h333, errNone);
    addRow("push3",          Push,     1, 0, 'h444, 'h444, errNone);
    addRow("pushFull",       Push,     1, 0, 'h555, 'h000, errFull);
    addRow("sizeFull",       Size,     1, 0, 'h000, 'h004, errNone);
    addRow("pop3",           Pop,      1, 0, 'h000, 'h444, errNone);
    addRow("pop2",           Pop,      1, 0, 'h000, 'h333, errNone);
    addRow("pop1",           Pop,      1, 0, 'h000, 'h222, errNone);
    addRow("pop0",           Pop,      1, 0, 'h000, 'h111, errNone);
    addRow("popEmpty",       Pop,      1, 0, 'h000, 'h000, errEmpty);
    addRow("pushThenPop",    Push,     1, 0, 'h9AB, 'h9AB, errNone);
    addRow("popAfterPush",   Pop,      1, 0, 'h000, 'h9AB, errNone);
    // Element operations, back to back on one element
    addRow("writeAlu",       Write,    0, 0, 'h100, 'h100, errNone);
    addRow("addBypass",      Add,      0, 0, 'h023, 'h123, errNone);
    addRow("subWrap",        Subtract, 0, 0, 'h200, 'hF23, errNone);
    addRow("readSub",        Read,     0, 0, 'h000, 'hF23, errNone);
    addRow("andOp",          And,      0, 0, 'h0F0, 'h020, errNone);
    addRow("orOp",           Or,       0, 0, 'h805, 'h825, errNone);
    addRow("xorOp",          Xor,      0, 0, 'hFFF, 'h7DA, errNone);
    addRow("readXor",        Read,     0, 0, 'h000, 'h7DA, errNone);
    addRow("writeSecond",    Write,    0, 1, 'h0FF, 'h0FF, errNone);
    addRow("addWrap",        Add,      0, 1, 'hF01, 'h000, errNone);
    addRow("readWrap",       Read,     0, 1, 'h000, 'h000, errNone);
    addRow("readFirstKept",  Read,     0, 0, 'h000, 'h7DA, errNone);
  endtask

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    clock          = 1'b0;
    reset          = 1'b0;
    commandStrobe  = 1'b0;
    opcode         = Alloc;
    arrayHandle    = '0;
    elementIndex   = '0;
    dataIn         = '0;
    cycle          = 0;
    valueErrors    = 0;
    protocolErrors = 0;
    buildTable();
    timeoutCycles = rows.size() + 20;

    fork
      begin
        #(timeoutCycles * 10);
        $display("Timeout after %0d cycles with %0d results still missing",
                 timeoutCycles, pending.size());
        $display("SIMULATION FAILED");
        $finish;
      end
    join_none

    repeat (5) @(posedge clock);
    #1 reset = 1'b1;

    foreach (rows[i]) begin
      @(posedge clock);
      #1;
      commandStrobe = 1'b1;
      opcode        = rows[i].op;
      arrayHandle   = rows[i].handle;
      elementIndex  = rows[i].index;
      dataIn        = rows[i].data;
      entry         = rows[i];
      entry.issued  = cycle;
      pending.push_back(entry);
    end
    @(posedge clock);
    #1 commandStrobe = 1'b0;

    while (pending.size() != 0) @(posedge clock);
    repeat (3) @(posedge clock);                // Catch any stray strobe

    $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
